// ==== files.f ====
verilog/avmm_pkg.sv
verilog/avmm_rdwr_if.sv
verilog/avmm_bridge_stage.sv
verilog/avmm_rdwr_reg.sv
verilog/avmm_rdwr_mem.sv
verilog/avmm_rdwr_subsys.sv
test/tb_clk_gen.sv
test/avmm_rdwr_tb.sv

// ==== Bender.yml ====
package:
  name: avmm_rdwr

sources:
  - verilog/avmm_pkg.sv
  - verilog/avmm_rdwr_if.sv
  - verilog/avmm_bridge_stage.sv
  - verilog/avmm_rdwr_reg.sv
  - verilog/avmm_rdwr_mem.sv
  - verilog/avmm_rdwr_subsys.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/avmm_rdwr_tb.sv

// ==== test/avmm_rdwr_tb.sv ====
// ==============================
// Testbench for the split read/write memory path
// Random reads and writes against a reference memory
// Expected response queues, in-order checks per channel
// Reset, readback, decode error, user echo, back-pressure
// ==============================

`default_nettype none

module avmm_rdwr_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT   = 2000;
    localparam int ADDR_SPAN = 1 << avmm_pkg::ADDR_WIDTH;

    logic                            clk;
    logic                            rst;
    logic                            rd_read;
    logic [avmm_pkg::ADDR_WIDTH-1:0] rd_address;
    logic [avmm_pkg::USER_WIDTH-1:0] rd_user;
    logic                            rd_waitrequest;
    logic                            rd_readdatavalid;
    logic [avmm_pkg::DATA_WIDTH-1:0] rd_readdata;
    logic [avmm_pkg::RESP_WIDTH-1:0] rd_response;
    logic [avmm_pkg::USER_WIDTH-1:0] rd_readresponseuser;
    logic                            wr_write;
    logic [avmm_pkg::ADDR_WIDTH-1:0] wr_address;
    logic [avmm_pkg::DATA_WIDTH-1:0] wr_writedata;
    logic [avmm_pkg::BE_WIDTH-1:0]   wr_byteenable;
    logic [avmm_pkg::USER_WIDTH-1:0] wr_user;
    logic                            wr_waitrequest;
    logic                            wr_writeresponsevalid;
    logic [avmm_pkg::RESP_WIDTH-1:0] wr_response;
    logic [avmm_pkg::USER_WIDTH-1:0] wr_writeresponseuser;
    logic                            mem_stall;

    // Reference memory and per-address count of requests in flight
    logic [avmm_pkg::DATA_WIDTH-1:0] model [avmm_pkg::MEM_WORDS];
    int                              rd_pend [ADDR_SPAN];
    int                              wr_pend [ADDR_SPAN];

    avmm_pkg::rd_rsp_t rd_exp_q [$];
    int                rd_addr_q [$];
    avmm_pkg::wr_rsp_t wr_exp_q [$];
    int                wr_addr_q [$];

    int errors;
    int tests_passed;
    int tests_failed;
    bit stress_on;

    tb_clk_gen clk_gen (.clk(clk));

    avmm_rdwr_subsys dut
    (
        .clk(clk), .rst(rst),
        .rd_read(rd_read), .rd_address(rd_address), .rd_user(rd_user),
        .rd_waitrequest(rd_waitrequest), .rd_readdatavalid(rd_readdatavalid),
        .rd_readdata(rd_readdata), .rd_response(rd_response),
        .rd_readresponseuser(rd_readresponseuser),
        .wr_write(wr_write), .wr_address(wr_address), .wr_writedata(wr_writedata),
        .wr_byteenable(wr_byteenable), .wr_user(wr_user),
        .wr_waitrequest(wr_waitrequest), .wr_writeresponsevalid(wr_writeresponsevalid),
        .wr_response(wr_response), .wr_writeresponseuser(wr_writeresponseuser),
        .mem_stall(mem_stall)
    );

    task automatic compare_rd(input avmm_pkg::rd_rsp_t got, input avmm_pkg::rd_rsp_t exp);
        if (got.data !== exp.data)
        begin
            $display("Mismatch rd_readdata: got %h, expected %h", got.data, exp.data);
            errors++;
        end
        if (got.response !== exp.response)
        begin
            $display("Mismatch rd_response: got %h, expected %h", got.response, exp.response);
            errors++;
        end
        if (got.user !== exp.user)
        begin
            $display("Mismatch rd_readresponseuser: got %h, expected %h", got.user, exp.user);
            errors++;
        end
    endtask

    task automatic compare_wr(input avmm_pkg::wr_rsp_t got, input avmm_pkg::wr_rsp_t exp);
        if (got.response !== exp.response)
        begin
            $display("Mismatch wr_response: got %h, expected %h", got.response, exp.response);
            errors++;
        end
        if (got.user !== exp.user)
        begin
            $display("Mismatch wr_writeresponseuser: got %h, expected %h", got.user, exp.user);
            errors++;
        end
    endtask

    // Both monitors sample at the falling edge, where the registered valids are stable
    always @(negedge clk)
    begin : rd_monitor
        avmm_pkg::rd_rsp_t got;
        int addr;
        if (!rst && rd_readdatavalid === 1'b1)
        begin
            got = '{data: rd_readdata, response: rd_response, user: rd_readresponseuser};
            if (rd_exp_q.size() == 0)
            begin
                $display("Read response arrived with no read outstanding");
                errors++;
            end
            else
            begin
                addr = rd_addr_q.pop_front();
                rd_pend[addr]--;
                compare_rd(got, rd_exp_q.pop_front());
            end
        end
    end

    always @(negedge clk)
    begin : wr_monitor
        avmm_pkg::wr_rsp_t got;
        int addr;
        if (!rst && wr_writeresponsevalid === 1'b1)
        begin
            got = '{response: wr_response, user: wr_writeresponseuser};
            if (wr_exp_q.size() == 0)
            begin
                $display("Write response arrived with no write outstanding");
                errors++;
            end
            else
            begin
                addr = wr_addr_q.pop_front();
                wr_pend[addr]--;
                compare_wr(got, wr_exp_q.pop_front());
            end
        end
    end

    // Entered and left 1 ns after a rising edge
    // An accepted request leaves the strobe high for back-to-back use
    task automatic issue_read(input int addr, input logic [avmm_pkg::USER_WIDTH-1:0] user);
        avmm_pkg::rd_rsp_t exp;
        int waited;
        waited = 0;
        rd_pend[addr]++;
        rd_read    = 1'b1;
        rd_address = avmm_pkg::ADDR_WIDTH'(addr);
        rd_user    = user;
        forever
        begin
            @(negedge clk);
            if (!rd_waitrequest)
            begin
                exp.user     = user;
                exp.data     = (addr < avmm_pkg::MEM_WORDS) ? model[addr] : '0;
                exp.response = (addr < avmm_pkg::MEM_WORDS) ?
                               avmm_pkg::RESP_OKAY : avmm_pkg::RESP_DECODEERROR;
                rd_exp_q.push_back(exp);
                rd_addr_q.push_back(addr);
                @(posedge clk);
                #1;
                return;
            end
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("Read request to address %h was never accepted", addr);
                errors++;
                rd_pend[addr]--;
                @(posedge clk);
                #1;
                rd_read = 1'b0;
                return;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issue_write(input int addr, input logic [avmm_pkg::DATA_WIDTH-1:0] data,
                               input logic [avmm_pkg::BE_WIDTH-1:0] be,
                               input logic [avmm_pkg::USER_WIDTH-1:0] user);
        avmm_pkg::wr_rsp_t exp;
        int waited;
        waited = 0;
        wr_pend[addr]++;
        wr_write      = 1'b1;
        wr_address    = avmm_pkg::ADDR_WIDTH'(addr);
        wr_writedata  = data;
        wr_byteenable = be;
        wr_user       = user;
        forever
        begin
            @(negedge clk);
            if (!wr_waitrequest)
            begin
                exp.user     = user;
                exp.response = avmm_pkg::RESP_DECODEERROR;
                if (addr < avmm_pkg::MEM_WORDS)
                begin
                    exp.response = avmm_pkg::RESP_OKAY;
                    for (int b = 0; b < avmm_pkg::BE_WIDTH; b++)
                    begin
                        if (be[b])
                            model[addr][8*b +: 8] = data[8*b +: 8];
                    end
                end
                wr_exp_q.push_back(exp);
                wr_addr_q.push_back(addr);
                @(posedge clk);
                #1;
                return;
            end
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("Write request to address %h was never accepted", addr);
                errors++;
                wr_pend[addr]--;
                @(posedge clk);
                #1;
                wr_write = 1'b0;
                return;
            end
            @(posedge clk);
            #1;
        end
    endtask

    // Reads skip addresses with a write in flight, so model data is final at acceptance
    task automatic read_stream(input int n, input int lo, input int hi);
        int addr;
        int done;
        int idle;
        done = 0;
        idle = 0;
        while (done < n && idle <= TIMEOUT)
        begin
            addr = $urandom_range(hi, lo);
            if (wr_pend[addr] != 0)
            begin
                rd_read = 1'b0;
                idle++;
                @(posedge clk);
                #1;
            end
            else
            begin
                issue_read(addr, avmm_pkg::USER_WIDTH'($urandom));
                done++;
            end
        end
        if (idle > TIMEOUT)
        begin
            $display("Read stream found no free address for too long");
            errors++;
        end
        rd_read = 1'b0;
    endtask

    task automatic write_stream(input int n, input int lo, input int hi, input bit full_be);
        int addr;
        int done;
        int idle;
        done = 0;
        idle = 0;
        while (done < n && idle <= TIMEOUT)
        begin
            addr = $urandom_range(hi, lo);
            if (rd_pend[addr] != 0)
            begin
                wr_write = 1'b0;
                idle++;
                @(posedge clk);
                #1;
            end
            else
            begin
                issue_write(addr, $urandom, full_be ? '1 : avmm_pkg::BE_WIDTH'($urandom),
                            avmm_pkg::USER_WIDTH'($urandom));
                done++;
            end
        end
        if (idle > TIMEOUT)
        begin
            $display("Write stream found no free address for too long");
            errors++;
        end
        wr_write = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((rd_exp_q.size() != 0 || wr_exp_q.size() != 0) && waited < TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        if (rd_exp_q.size() != 0 || wr_exp_q.size() != 0)
        begin
            $display("Timed out with %0d read and %0d write responses missing",
                     rd_exp_q.size(), wr_exp_q.size());
            errors++;
            rd_exp_q.delete();
            rd_addr_q.delete();
            wr_exp_q.delete();
            wr_addr_q.delete();
        end
        // A stray extra response shows up in this quiet window
        repeat (10) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before)
        begin
            $display("Test %s: ok", name);
            tests_passed++;
        end
        else
        begin
            $display("Test %s: %0d errors", name, errors - errs_before);
            tests_failed++;
        end
    endtask

    task automatic check_valids_low(input string when);
        if (rd_readdatavalid !== 1'b0 || wr_writeresponsevalid !== 1'b0)
        begin
            $display("A response valid was not low %s", when);
            errors++;
        end
    endtask

    initial
    begin : main
        int seed;
        int errs;
        int waited;
        seed = 51947;
        void'($urandom(seed));
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        stress_on     = 1'b0;
        rst           = 1'b1;
        rd_read       = 1'b0;
        rd_address    = '0;
        rd_user       = '0;
        wr_write      = 1'b0;
        wr_address    = '0;
        wr_writedata  = '0;
        wr_byteenable = '0;
        wr_user       = '0;
        mem_stall     = 1'b0;

        // Test 1
        errs = errors;
        repeat (3)
        begin
            @(posedge clk);
            #1;
            check_valids_low("during reset");
        end
        rst    = 1'b0;
        waited = 0;
        while ((rd_waitrequest !== 1'b0 || wr_waitrequest !== 1'b0) && waited < TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (rd_waitrequest !== 1'b0 || wr_waitrequest !== 1'b0)
        begin
            $display("Waitrequest stayed high after reset");
            errors++;
        end
        repeat (4)
        begin
            @(negedge clk);
            check_valids_low("after reset");
        end
        @(posedge clk);
        #1;
        report_test("reset state", errs);

        // Test 2 starts with a full fill so every byte is known
        errs = errors;
        for (int a = 0; a < avmm_pkg::MEM_WORDS; a++)
            issue_write(a, $urandom, '1, avmm_pkg::USER_WIDTH'($urandom));
        wr_write = 1'b0;
        write_stream(40, 0, avmm_pkg::MEM_WORDS - 1, 1'b0);
        wait_drain();
        read_stream(80, 0, avmm_pkg::MEM_WORDS - 1);
        wait_drain();
        report_test("write then read back", errs);

        // Test 3
        errs = errors;
        write_stream(16, avmm_pkg::MEM_WORDS, ADDR_SPAN - 1, 1'b1);
        read_stream(16, avmm_pkg::MEM_WORDS, ADDR_SPAN - 1);
        wait_drain();
        read_stream(64, 0, avmm_pkg::MEM_WORDS - 1);
        wait_drain();
        report_test("decode error", errs);

        // Test 4
        errs = errors;
        fork
            read_stream(60, 0, 79);
            write_stream(60, 0, 79, 1'b0);
        join
        wait_drain();
        report_test("user echo and order", errs);

        // Test 5
        errs = errors;
        stress_on = 1'b1;
        fork
            begin
                fork
                    read_stream(300, 0, 79);
                    write_stream(300, 0, 79, 1'b0);
                join
                stress_on = 1'b0;
            end
            begin
                while (stress_on)
                begin
                    mem_stall = 1'($urandom_range(1, 0));
                    @(posedge clk);
                    #1;
                end
                mem_stall = 1'b0;
            end
        join
        wait_drain();
        report_test("back-pressure", errs);

        $display("Tests: %0d ok, %0d with errors, %0d errors in total",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
// ==============================
// Testbench clock source
// 10 ns period, starts low
// ==============================

`default_nettype none

module tb_clk_gen
(
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 5ns;

    initial
    begin
        clk = 1'b0;
        forever
            #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== verilog/avmm_rdwr_subsys.sv ====
// ==============================
// Top level of the memory path
// Host ports packed onto the bus
// Register pipeline and memory endpoint
// ==============================

`default_nettype none

module avmm_rdwr_subsys
(
    input  wire clk,
    input  wire rst,

    // Read channel
    input  logic                            rd_read,
    input  logic [avmm_pkg::ADDR_WIDTH-1:0] rd_address,
    input  logic [avmm_pkg::USER_WIDTH-1:0] rd_user,
    output logic                            rd_waitrequest,
    output logic                            rd_readdatavalid,
    output logic [avmm_pkg::DATA_WIDTH-1:0] rd_readdata,
    output logic [avmm_pkg::RESP_WIDTH-1:0] rd_response,
    output logic [avmm_pkg::USER_WIDTH-1:0] rd_readresponseuser,

    // Write channel
    input  logic                            wr_write,
    input  logic [avmm_pkg::ADDR_WIDTH-1:0] wr_address,
    input  logic [avmm_pkg::DATA_WIDTH-1:0] wr_writedata,
    input  logic [avmm_pkg::BE_WIDTH-1:0]   wr_byteenable,
    input  logic [avmm_pkg::USER_WIDTH-1:0] wr_user,
    output logic                            wr_waitrequest,
    output logic                            wr_writeresponsevalid,
    output logic [avmm_pkg::RESP_WIDTH-1:0] wr_response,
    output logic [avmm_pkg::USER_WIDTH-1:0] wr_writeresponseuser,

    // Holds off the memory endpoint
    input  logic                            mem_stall
);

    avmm_rdwr_if host_bus ();
    avmm_rdwr_if mem_bus ();

    assign host_bus.rd_read  = rd_read;
    assign host_bus.rd_req   = '{address: rd_address, user: rd_user};
    assign host_bus.wr_write = wr_write;
    assign host_bus.wr_req   = '{address: wr_address, data: wr_writedata,
                                 byteenable: wr_byteenable, user: wr_user};

    assign rd_waitrequest        = host_bus.rd_waitrequest;
    assign rd_readdatavalid      = host_bus.rd_readdatavalid;
    assign rd_readdata           = host_bus.rd_rsp.data;
    assign rd_response           = host_bus.rd_rsp.response;
    assign rd_readresponseuser   = host_bus.rd_rsp.user;
    assign wr_waitrequest        = host_bus.wr_waitrequest;
    assign wr_writeresponsevalid = host_bus.wr_writeresponsevalid;
    assign wr_response           = host_bus.wr_rsp.response;
    assign wr_writeresponseuser  = host_bus.wr_rsp.user;

    avmm_rdwr_reg #(.N_STAGES(avmm_pkg::N_REG_STAGES)) pipe
    (
        .clk,
        .rst,
        .host_side(host_bus),
        .mem_side(mem_bus)
    );

    avmm_rdwr_mem mem
    (
        .clk,
        .rst,
        .stall(mem_stall),
        .bus(mem_bus)
    );

endmodule

`default_nettype wire

// ==== verilog/avmm_rdwr_mem.sv ====
// ==============================
// On-chip memory endpoint for the split read/write bus
// Level based stall, byte enables, fixed read latency
// Decode error above the implemented words, user echo
// ==============================

`default_nettype none

module avmm_rdwr_mem
(
    input  wire  clk,
    input  wire  rst,
    input  logic stall,
    avmm_rdwr_if.agent bus
);

    logic [avmm_pkg::DATA_WIDTH-1:0] mem [avmm_pkg::MEM_WORDS];

    logic rd_accept;
    logic wr_accept;
    logic rd_in_range;
    logic wr_in_range;

    // Read response pipeline, last entry drives the bus
    logic [avmm_pkg::RD_LATENCY-1:0] rd_v;
    avmm_pkg::rd_rsp_t               rd_p [avmm_pkg::RD_LATENCY];

    assign bus.rd_waitrequest = stall;
    assign bus.wr_waitrequest = stall;

    assign rd_accept = bus.rd_read && !stall;
    assign wr_accept = bus.wr_write && !stall;

    assign rd_in_range = bus.rd_req.address < avmm_pkg::ADDR_WIDTH'(avmm_pkg::MEM_WORDS);
    assign wr_in_range = bus.wr_req.address < avmm_pkg::ADDR_WIDTH'(avmm_pkg::MEM_WORDS);

    // Byte-wise write, out of range writes are dropped
    always_ff @(posedge clk)
    begin
        if (wr_accept && wr_in_range)
        begin
            for (int b = 0; b < avmm_pkg::BE_WIDTH; b++)
            begin
                if (bus.wr_req.byteenable[b])
                    mem[bus.wr_req.address[avmm_pkg::MEM_ADDR_WIDTH-1:0]][8*b +: 8]
                        <= bus.wr_req.data[8*b +: 8];
            end
        end
    end

    // Write response one cycle after acceptance
    always_ff @(posedge clk)
    begin
        if (rst)
            bus.wr_writeresponsevalid <= 1'b0;
        else
            bus.wr_writeresponsevalid <= wr_accept;
        bus.wr_rsp.response <= wr_in_range ? avmm_pkg::RESP_OKAY : avmm_pkg::RESP_DECODEERROR;
        bus.wr_rsp.user     <= bus.wr_req.user;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            rd_v <= '0;
        else
        begin
            rd_v[0] <= rd_accept;
            for (int i = 1; i < avmm_pkg::RD_LATENCY; i++)
                rd_v[i] <= rd_v[i-1];
        end
    end

    // Data is sampled at acceptance, a same-cycle write is not visible
    always_ff @(posedge clk)
    begin
        rd_p[0].data     <= rd_in_range ?
                            mem[bus.rd_req.address[avmm_pkg::MEM_ADDR_WIDTH-1:0]] : '0;
        rd_p[0].response <= rd_in_range ? avmm_pkg::RESP_OKAY : avmm_pkg::RESP_DECODEERROR;
        rd_p[0].user     <= bus.rd_req.user;
        for (int i = 1; i < avmm_pkg::RD_LATENCY; i++)
            rd_p[i] <= rd_p[i-1];
    end

    assign bus.rd_readdatavalid = rd_v[avmm_pkg::RD_LATENCY-1];
    assign bus.rd_rsp           = rd_p[avmm_pkg::RD_LATENCY-1];

endmodule

`default_nettype wire

// ==== verilog/avmm_rdwr_reg.sv ====
// ==============================
// Configurable register pipeline for the split read/write bus
// Chains bridge stages on both channels
// Zero stages connects the two sides directly
// ==============================

`default_nettype none

module avmm_rdwr_reg
#(
    parameter int unsigned N_STAGES = 1
)
(
    input  wire clk,
    input  wire rst,
    avmm_rdwr_if.agent host_side,
    avmm_rdwr_if.host  mem_side
);

    if (N_STAGES == 0)
    begin : wires
        assign mem_side.rd_read                = host_side.rd_read;
        assign mem_side.rd_req                 = host_side.rd_req;
        assign host_side.rd_waitrequest        = mem_side.rd_waitrequest;
        assign host_side.rd_readdatavalid      = mem_side.rd_readdatavalid;
        assign host_side.rd_rsp                = mem_side.rd_rsp;
        assign mem_side.wr_write               = host_side.wr_write;
        assign mem_side.wr_req                 = host_side.wr_req;
        assign host_side.wr_waitrequest        = mem_side.wr_waitrequest;
        assign host_side.wr_writeresponsevalid = mem_side.wr_writeresponsevalid;
        assign host_side.wr_rsp                = mem_side.wr_rsp;
    end
    else
    begin : regs
        // Index 0 is the host side, index N_STAGES the memory side
        logic              rd_v      [N_STAGES+1];
        avmm_pkg::rd_req_t rd_d      [N_STAGES+1];
        logic              rd_wait   [N_STAGES+1];
        logic              rd_rsp_v  [N_STAGES+1];
        avmm_pkg::rd_rsp_t rd_rsp_d  [N_STAGES+1];
        logic              wr_v      [N_STAGES+1];
        avmm_pkg::wr_req_t wr_d      [N_STAGES+1];
        logic              wr_wait   [N_STAGES+1];
        logic              wr_rsp_v  [N_STAGES+1];
        avmm_pkg::wr_rsp_t wr_rsp_d  [N_STAGES+1];

        assign rd_v[0]                         = host_side.rd_read;
        assign rd_d[0]                         = host_side.rd_req;
        assign host_side.rd_waitrequest        = rd_wait[0];
        assign host_side.rd_readdatavalid      = rd_rsp_v[0];
        assign host_side.rd_rsp                = rd_rsp_d[0];
        assign wr_v[0]                         = host_side.wr_write;
        assign wr_d[0]                         = host_side.wr_req;
        assign host_side.wr_waitrequest        = wr_wait[0];
        assign host_side.wr_writeresponsevalid = wr_rsp_v[0];
        assign host_side.wr_rsp                = wr_rsp_d[0];

        assign mem_side.rd_read      = rd_v[N_STAGES];
        assign mem_side.rd_req       = rd_d[N_STAGES];
        assign rd_wait[N_STAGES]     = mem_side.rd_waitrequest;
        assign rd_rsp_v[N_STAGES]    = mem_side.rd_readdatavalid;
        assign rd_rsp_d[N_STAGES]    = mem_side.rd_rsp;
        assign mem_side.wr_write     = wr_v[N_STAGES];
        assign mem_side.wr_req       = wr_d[N_STAGES];
        assign wr_wait[N_STAGES]     = mem_side.wr_waitrequest;
        assign wr_rsp_v[N_STAGES]    = mem_side.wr_writeresponsevalid;
        assign wr_rsp_d[N_STAGES]    = mem_side.wr_rsp;

        for (genvar s = 0; s < N_STAGES; s++)
        begin : p
            avmm_bridge_stage #(.REQ_T(avmm_pkg::rd_req_t), .RSP_T(avmm_pkg::rd_rsp_t)) bridge_rd
            (
                .clk, .rst,
                .up_req(rd_v[s]), .up_req_data(rd_d[s]), .up_wait(rd_wait[s]),
                .up_rsp_valid(rd_rsp_v[s]), .up_rsp_data(rd_rsp_d[s]),
                .dn_req(rd_v[s+1]), .dn_req_data(rd_d[s+1]), .dn_wait(rd_wait[s+1]),
                .dn_rsp_valid(rd_rsp_v[s+1]), .dn_rsp_data(rd_rsp_d[s+1])
            );

            avmm_bridge_stage #(.REQ_T(avmm_pkg::wr_req_t), .RSP_T(avmm_pkg::wr_rsp_t)) bridge_wr
            (
                .clk, .rst,
                .up_req(wr_v[s]), .up_req_data(wr_d[s]), .up_wait(wr_wait[s]),
                .up_rsp_valid(wr_rsp_v[s]), .up_rsp_data(wr_rsp_d[s]),
                .dn_req(wr_v[s+1]), .dn_req_data(wr_d[s+1]), .dn_wait(wr_wait[s+1]),
                .dn_rsp_valid(wr_rsp_v[s+1]), .dn_rsp_data(wr_rsp_d[s+1])
            );
        end
    end

endmodule

`default_nettype wire

// ==== verilog/avmm_bridge_stage.sv ====
// ==============================
// Registered Avalon pipeline stage for one channel
// Main request register plus one skid entry
// Registered response valid and payload
// ==============================

`default_nettype none

module avmm_bridge_stage
#(
    parameter type REQ_T = logic,
    parameter type RSP_T = logic
)
(
    input  wire  clk,
    input  wire  rst,

    input  logic up_req,
    input  REQ_T up_req_data,
    output logic up_wait,
    output logic up_rsp_valid,
    output RSP_T up_rsp_data,

    output logic dn_req,
    output REQ_T dn_req_data,
    input  logic dn_wait,
    input  logic dn_rsp_valid,
    input  RSP_T dn_rsp_data
);

    logic skid_valid;
    REQ_T skid_data;
    logic up_accept;
    logic main_free;

    // Waitrequest comes straight from a flop, so no path runs back through the stage
    assign up_wait   = skid_valid;
    assign up_accept = up_req && !skid_valid;

    // Main register is empty or drains this cycle
    assign main_free = !dn_req || !dn_wait;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dn_req     <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (main_free)
        begin
            // Skid entry has priority, it is older than anything upstream
            dn_req     <= skid_valid || up_accept;
            skid_valid <= 1'b0;
        end
        else if (up_accept)
        begin
            // Downstream just started waiting, park this one
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (main_free)
        begin
            dn_req_data <= skid_valid ? skid_data : up_req_data;
        end
        if (!main_free && up_accept)
        begin
            skid_data <= up_req_data;
        end
    end

    // Responses are never stalled, one register is enough
    always_ff @(posedge clk)
    begin
        if (rst)
            up_rsp_valid <= 1'b0;
        else
            up_rsp_valid <= dn_rsp_valid;
        up_rsp_data <= dn_rsp_data;
    end

endmodule

`default_nettype wire

// ==== verilog/avmm_rdwr_if.sv ====
// ==============================
// Avalon split read/write channel bundle
// Host and agent modports
// ==============================

`default_nettype none

interface avmm_rdwr_if;

    // Read channel
    logic                 rd_read;
    avmm_pkg::rd_req_t    rd_req;
    logic                 rd_waitrequest;
    logic                 rd_readdatavalid;
    avmm_pkg::rd_rsp_t    rd_rsp;

    // Write channel
    logic                 wr_write;
    avmm_pkg::wr_req_t    wr_req;
    logic                 wr_waitrequest;
    logic                 wr_writeresponsevalid;
    avmm_pkg::wr_rsp_t    wr_rsp;

    // Side that issues requests and collects responses
    modport host
    (
        output rd_read,
        output rd_req,
        input  rd_waitrequest,
        input  rd_readdatavalid,
        input  rd_rsp,
        output wr_write,
        output wr_req,
        input  wr_waitrequest,
        input  wr_writeresponsevalid,
        input  wr_rsp
    );

    // Side that serves requests
    modport agent
    (
        input  rd_read,
        input  rd_req,
        output rd_waitrequest,
        output rd_readdatavalid,
        output rd_rsp,
        input  wr_write,
        input  wr_req,
        output wr_waitrequest,
        output wr_writeresponsevalid,
        output wr_rsp
    );

endinterface

`default_nettype wire

// ==== verilog/avmm_pkg.sv ====
// ==============================
// Shared definitions for the Avalon split read/write memory path
// Bus widths, memory size, read latency and pipeline depth
// Response codes and the request and response structs
// ==============================

`default_nettype none

package avmm_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 7;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = DATA_WIDTH / 8;
    localparam int USER_WIDTH = 4;
    localparam int RESP_WIDTH = 2;

    // Memory endpoint geometry, addresses at or above MEM_WORDS decode to an error
    localparam int MEM_WORDS      = 64;
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_WORDS);
    localparam int RD_LATENCY     = 2;

    // Register stages between host port and memory
    localparam int N_REG_STAGES = 2;

    // Avalon response codes
    localparam logic [RESP_WIDTH-1:0] RESP_OKAY        = 2'd0;
    localparam logic [RESP_WIDTH-1:0] RESP_DECODEERROR = 2'd3;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] address;
        logic [USER_WIDTH-1:0] user;
    } rd_req_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0] data;
        logic [BE_WIDTH-1:0]   byteenable;
        logic [USER_WIDTH-1:0] user;
    } wr_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [RESP_WIDTH-1:0] response;
        logic [USER_WIDTH-1:0] user;
    } rd_rsp_t;

    typedef struct packed {
        logic [RESP_WIDTH-1:0] response;
        logic [USER_WIDTH-1:0] user;
    } wr_rsp_t;

endpackage

`default_nettype wire
